//--- sim.f
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/entry_fifo.sv
hdl/cmd_decode.sv
hdl/cmd_execute.sv
hdl/result_framer.sv
hdl/settings_readback_ctrl.sv
verification/tb_settings_readback.sv

//--- Makefile
TOP = tb_settings_readback

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "^all tests passed$$"

clean:
	rm -rf obj_dir

//--- verification/tb_settings_readback.sv
// --------------------
// tb_settings_readback
// random command packets into the controller, strobes and
// responses checked against queues of expected values
// --------------------
`include "ctrl_config.svh"

module tb_settings_readback;
    import ctrl_pkg::*;

    localparam int num_packets = 40;
    localparam int stall_cycles = 300;
    localparam int cycle_limit = num_packets * 40 + stall_cycles;

    // expected strobe
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
        logic [63:0] trig;
    } exp_strobe_t;

    // expected response
    typedef struct packed {
        logic [31:0] hdr;
        logic [31:0] rb;
        logic        timed;
        logic [63:0] trig;
        logic [63:0] sent;
    } exp_resp_t;

    logic         clock;
    logic         reset;
    logic [63:0]  vita_time;
    stream_word_t in_word;
    logic         in_valid;
    logic         in_ready;
    stream_word_t out_word;
    logic         out_valid;
    logic         out_ready;
    readback_t    readback;
    logic         strobe;
    logic [7:0]   addr;
    logic [31:0]  data;

    exp_strobe_t strobe_q[$];
    exp_resp_t   resp_q[$];

    // values for the next rising edge, set on the falling edge
    logic         strobe_expected;
    logic [7:0]   exp_addr;
    logic [31:0]  exp_data;
    logic [63:0]  exp_trig;
    logic         resp_expected;
    logic         chk_exact;
    stream_word_t exp_word;
    logic [31:0]  data_mask;
    int           check_idx;
    logic         chk_time;
    logic         time_ok;
    logic [63:0]  seen_ticks;
    logic [31:0]  hi_word;
    int           word_idx;

    int          check_errors;
    int          other_errors;
    int          cycles;
    int          responses_seen;
    int          stall_seen;
    logic [15:0] stim_state;
    logic [15:0] ready_state;

    settings_readback_ctrl dut0 (
        .clock(clock), .reset(reset), .vita_time(vita_time), .in_word(in_word),
        .in_valid(in_valid), .in_ready(in_ready), .out_word(out_word),
        .out_valid(out_valid), .out_ready(out_ready), .readback(readback),
        .strobe(strobe), .addr(addr), .data(data)
    );

    // --------------------
    // random bits
    // --------------------

    // galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb)
            s = s ^ 16'hb400;
        return s;
    endfunction

    // one step per bit taken
    task automatic take_bits(inout logic [15:0] s, input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_step(s);
            v[i] = s[0];
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // --------------------
    // stimulus
    // --------------------

    // transfer happens on the rising edge after this returns
    task automatic send_word(input logic sof, input logic eof, input logic [31:0] w);
        int waits;
        @(negedge clock);
        in_word.sof = sof;
        in_word.eof = eof;
        in_word.data = w;
        in_valid = 1'b1;
        waits = 0;
        while (!in_ready) begin
            waits++;
            @(negedge clock);
        end
        // one idle cycle is the hand off after eof, a longer wait means a full queue
        if (waits > 1)
            stall_seen++;
    endtask

    task automatic send_packet(input int seq);
        logic [15:0] sid, cid, tsi, tsf, trail, poke, a, offset, d;
        logic [31:0] hdr;
        logic [31:0] cmd_data;
        logic [31:0] vhdr;
        logic [63:0] trig;
        logic [63:0] sent;
        take_bits(stim_state, 1, sid);
        take_bits(stim_state, 1, cid);
        take_bits(stim_state, 1, tsi);
        take_bits(stim_state, 1, tsf);
        take_bits(stim_state, 2, trail);
        take_bits(stim_state, 1, poke);
        take_bits(stim_state, 8, a);
        take_bits(stim_state, 5, offset);
        take_bits(stim_state, 16, d);
        hdr = {12'd0, 4'(seq), 7'd0, poke[0], a[7:0]};
        cmd_data = {d, 16'(seq)};
        vhdr = {3'd0, sid[0], cid[0], 3'd0, tsi[0] ? 2'b01 : 2'b00,
                tsf[0] ? 2'b01 : 2'b00, 20'(seq)};
        sent = vita_time;
        trig = tsf[0] ? vita_time + 64'(offset[4:0]) : 64'd0;
        if (poke[0])
            strobe_q.push_back('{a[7:0], cmd_data, trig});
        resp_q.push_back('{hdr, readback[a[3:0]], tsf[0], trig, sent});
        send_word(1'b1, 1'b0, 32'h0001_0000);
        send_word(1'b0, 1'b0, vhdr);
        if (sid[0])
            send_word(1'b0, 1'b0, 32'h1111_0000 + 32'(seq));
        if (cid[0]) begin
            send_word(1'b0, 1'b0, 32'h2222_0000);
            send_word(1'b0, 1'b0, 32'h2222_0001);
        end
        if (tsi[0])
            send_word(1'b0, 1'b0, 32'h3333_0000);
        if (tsf[0]) begin
            send_word(1'b0, 1'b0, trig[63:32]);
            send_word(1'b0, 1'b0, trig[31:0]);
        end
        send_word(1'b0, 1'b0, hdr);
        send_word(1'b0, trail[1:0] == 2'd0, cmd_data);
        // trailing words, dropped by decode
        for (int i = 1; i <= int'(trail[1:0]); i++)
            send_word(1'b0, i == int'(trail[1:0]), 32'hdead_0000 + 32'(i));
    endtask

    // --------------------
    // expected values and out_ready, on the falling edge
    // --------------------
    always @(negedge clock) begin
        logic [15:0] r;
        vita_time = vita_time + 64'd1;
        if (reset || cycles < stall_cycles) begin
            out_ready = 1'b0;
        end else begin
            take_bits(ready_state, 2, r);
            out_ready = (r[1:0] != 2'b00);
        end
        if (strobe) begin
            strobe_expected = (strobe_q.size() > 0);
            if (strobe_expected) begin
                exp_addr = strobe_q[0].addr;
                exp_data = strobe_q[0].data;
                exp_trig = strobe_q[0].trig;
                strobe_q.pop_front();
            end
        end
        chk_exact = 1'b0;
        chk_time = 1'b0;
        resp_expected = (resp_q.size() > 0);
        if (out_valid && resp_expected) begin
            exp_word.sof = (word_idx == 0);
            exp_word.eof = (word_idx == 6);
            chk_exact = 1'b1;
            check_idx = word_idx;
            data_mask = '1;
            case (word_idx)
                0: exp_word.data = (32'(`CTRL_PROT_DEST) << 17) | 32'h0001_0000
                                   | 32'(`CTRL_RESP_BYTES);
                1: exp_word.data = (32'h501 << 20) | (32'(resp_q[0].hdr[19:16]) << 16) | 32'd6;
                2: exp_word.data = `CTRL_SID;
                // ticks only get a range check, the flags are still compared
                3: begin
                    data_mask = '0;
                    exp_word.data = 32'd0;
                    hi_word = out_word.data;
                end
                4: begin
                    data_mask = '0;
                    exp_word.data = 32'd0;
                    seen_ticks = {hi_word, out_word.data};
                    chk_time = 1'b1;
                    if (resp_q[0].timed)
                        time_ok = (seen_ticks >= resp_q[0].trig);
                    else
                        time_ok = (seen_ticks > resp_q[0].sent) && (seen_ticks <= vita_time);
                end
                5: exp_word.data = resp_q[0].hdr;
                default: exp_word.data = resp_q[0].rb;
            endcase
            if (out_ready) begin
                if (word_idx == 6) begin
                    word_idx = 0;
                    resp_q.pop_front();
                    responses_seen++;
                end else begin
                    word_idx++;
                end
            end
        end
    end

    // --------------------
    // checking assertions
    // --------------------
    strobe_wanted: assert property (@(posedge clock) disable iff (reset)
        strobe |-> strobe_expected)
    else begin
        check_errors++;
        $display("strobe at time %0t with no poke command pending", $time);
    end

    strobe_addr: assert property (@(posedge clock) disable iff (reset)
        strobe && strobe_expected |-> addr == exp_addr)
    else begin
        check_errors++;
        $display("CHECK FAILED time %0t addr %h expected %h", $time, $sampled(addr), exp_addr);
    end

    strobe_data: assert property (@(posedge clock) disable iff (reset)
        strobe && strobe_expected |-> data == exp_data)
    else begin
        check_errors++;
        $display("CHECK FAILED time %0t data %h expected %h", $time, $sampled(data), exp_data);
    end

    // strobe follows the action by one cycle, so time is past the trigger
    strobe_time: assert property (@(posedge clock) disable iff (reset)
        strobe && strobe_expected |-> vita_time > exp_trig)
    else begin
        check_errors++;
        $display("CHECK FAILED time %0t vita_time %0d expected above %0d",
                 $time, $sampled(vita_time), exp_trig);
    end

    resp_wanted: assert property (@(posedge clock) disable iff (reset)
        out_valid |-> resp_expected)
    else begin
        check_errors++;
        $display("response at time %0t with no command pending", $time);
    end

    resp_word: assert property (@(posedge clock) disable iff (reset)
        out_valid && out_ready && chk_exact
            |-> {out_word.eof, out_word.sof, out_word.data & data_mask} == exp_word)
    else begin
        check_errors++;
        $display("CHECK FAILED time %0t out_word %h expected %h word %0d",
                 $time, $sampled(out_word), exp_word, check_idx);
    end

    resp_time: assert property (@(posedge clock) disable iff (reset)
        out_valid && out_ready && chk_time |-> time_ok)
    else begin
        check_errors++;
        $display("response ticks %0d out of range at time %0t", seen_ticks, $time);
    end

    // unaccepted words stay on the bus
    resp_hold: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && out_word == $past(out_word))
    else begin
        check_errors++;
        $display("CHECK FAILED time %0t out_word %h expected %h",
                 $time, $sampled(out_word), $past(out_word));
    end

    // --------------------
    // timeout
    // --------------------
    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d check, %0d other", check_errors, other_errors + 1);
            $display("tests failed");
            $finish;
        end
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        reset = 1'b1;
        vita_time = 64'd0;
        in_word = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        check_errors = 0;
        other_errors = 0;
        cycles = 0;
        responses_seen = 0;
        stall_seen = 0;
        word_idx = 0;
        check_idx = 0;
        data_mask = '1;
        strobe_expected = 1'b0;
        resp_expected = 1'b0;
        chk_exact = 1'b0;
        chk_time = 1'b0;
        time_ok = 1'b0;
        stim_state = 16'd17;
        ready_state = 16'd17;
        for (int i = 0; i < 16; i++)
            readback[i] = 32'h5a00_0000 + 32'(i) * 32'h0101_0101;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int p = 0; p < num_packets; p++)
            send_packet(p);
        @(negedge clock);
        in_valid = 1'b0;
        wait (responses_seen == num_packets);
        repeat (10) @(posedge clock);
        if (strobe_q.size() != 0) begin
            other_errors++;
            $display("%0d poke commands never strobed", strobe_q.size());
        end
        if (resp_q.size() != 0 || out_valid) begin
            other_errors++;
            $display("responses left over at the end of the run");
        end
        if (stall_seen == 0) begin
            other_errors++;
            $display("in_ready never dropped while the queues were full");
        end
        $display("errors: %0d check, %0d other", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- hdl/settings_readback_ctrl.sv
// --------------------
// settings_readback_ctrl
// packet driven settings bus and readback controller
// decode, command queue, execute, result queue, response framer
// --------------------
module settings_readback_ctrl (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [63:0]            vita_time,
    input  ctrl_pkg::stream_word_t in_word,
    input  logic                   in_valid,
    output logic                   in_ready,
    output ctrl_pkg::stream_word_t out_word,
    output logic                   out_valid,
    input  logic                   out_ready,
    input  ctrl_pkg::readback_t    readback,
    output logic                   strobe,
    output logic [7:0]             addr,
    output logic [31:0]            data
);
    import ctrl_pkg::*;

    // command queue
    command_t cmd_in;
    command_t cmd_head;
    logic     cmd_write;
    logic     cmd_read;
    logic     cmd_full;
    logic     cmd_empty;

    // result queue
    result_t res_in;
    result_t res_head;
    logic    res_write;
    logic    res_read;
    logic    res_full;
    logic    res_empty;

    cmd_decode decode (
        .clock(clock), .reset(reset), .in_word(in_word), .in_valid(in_valid),
        .cmd_full(cmd_full), .in_ready(in_ready), .cmd_write(cmd_write), .cmd_entry(cmd_in)
    );

    entry_fifo #(.width($bits(command_t))) cmd_fifo (
        .clock(clock), .reset(reset), .write(cmd_write), .write_data(cmd_in),
        .read(cmd_read), .read_data(cmd_head), .full(cmd_full), .empty(cmd_empty)
    );

    cmd_execute execute (
        .clock(clock), .reset(reset), .vita_time(vita_time), .cmd_entry(cmd_head),
        .cmd_empty(cmd_empty), .readback(readback), .res_full(res_full),
        .cmd_read(cmd_read), .res_write(res_write), .res_entry(res_in),
        .strobe(strobe), .addr(addr), .data(data)
    );

    entry_fifo #(.width($bits(result_t))) res_fifo (
        .clock(clock), .reset(reset), .write(res_write), .write_data(res_in),
        .read(res_read), .read_data(res_head), .full(res_full), .empty(res_empty)
    );

    result_framer framer (
        .clock(clock), .reset(reset), .res_entry(res_head), .res_empty(res_empty),
        .out_ready(out_ready), .res_read(res_read), .out_word(out_word), .out_valid(out_valid)
    );

endmodule

//--- hdl/result_framer.sv
// --------------------
// result_framer
// turns each result entry into a seven word response packet
// --------------------
`include "ctrl_config.svh"

module result_framer (
    input  logic                   clock,
    input  logic                   reset,
    input  ctrl_pkg::result_t      res_entry,
    input  logic                   res_empty,
    input  logic                   out_ready,
    output logic                   res_read,
    output ctrl_pkg::stream_word_t out_word,
    output logic                   out_valid
);
    import ctrl_pkg::*;

    frame_state_t state;
    logic         sending;
    logic [31:0]  prot_word;

    // a response is offered whenever a result waits
    assign out_valid = !res_empty;
    assign sending = out_valid && out_ready;
    // pop only once the last word has gone
    assign res_read = sending && (state == rb_data);

    // byte count, frame flag and destination
    assign prot_word = {13'd0, `CTRL_PROT_DEST, 1'b1, 16'(`CTRL_RESP_BYTES)};

    // --------------------
    // word index
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= prot_hdr;
        end else if (sending) begin
            if (state == rb_data)
                state <= prot_hdr;
            else
                state <= frame_state_t'(state + 3'd1);
        end
    end

    // --------------------
    // word select
    // --------------------
    always_comb begin
        out_word.sof = (state == prot_hdr);
        out_word.eof = (state == rb_data);
        case (state)
            prot_hdr: out_word.data = prot_word;
            // fixed 0x501 pattern, seq and six words of length
            vrt_hdr: out_word.data = {12'h501, res_entry.hdr[19:16], 16'd6};
            vrt_sid: out_word.data = `CTRL_SID;
            tsf_hi: out_word.data = res_entry.ticks[63:32];
            tsf_lo: out_word.data = res_entry.ticks[31:0];
            // header echoed back to the host
            rb_hdr: out_word.data = res_entry.hdr;
            rb_data: out_word.data = res_entry.data;
            default: out_word.data = 32'd0;
        endcase
    end

    // a refused word stays on the bus until it is taken
    word_hold: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_word));

endmodule

//--- hdl/cmd_execute.sv
// --------------------
// cmd_execute
// runs queued commands at their trigger time, pokes the settings bus
// and captures the selected readback word into a result
// --------------------
module cmd_execute (
    input  logic                clock,
    input  logic                reset,
    input  logic [63:0]         vita_time,
    input  ctrl_pkg::command_t  cmd_entry,
    input  logic                cmd_empty,
    input  ctrl_pkg::readback_t readback,
    input  logic                res_full,
    output logic                cmd_read,
    output logic                res_write,
    output ctrl_pkg::result_t   res_entry,
    output logic                strobe,
    output logic [7:0]          addr,
    output logic [31:0]         data
);
    import ctrl_pkg::*;

    exec_state_t state;
    // copy of the fifo head taken when the command loads
    command_t    cmd_reg;
    logic [31:0] rb_data;
    logic        time_due;
    logic        action;

    // at or past the trigger time
    assign time_due = (vita_time >= cmd_reg.ticks);

    // untimed commands fire as soon as the result has room
    assign action = (state == exec_event) && !res_full
        && (!cmd_reg.has_time || time_due);

    // head leaves the queue as its result enters the other one
    assign cmd_read = action;
    assign res_write = action;

    always_comb begin
        res_entry.ticks = vita_time;
        res_entry.hdr = cmd_reg.hdr;
        res_entry.data = rb_data;
    end

    // --------------------
    // load and event
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= exec_load;
        end else begin
            case (state)
                exec_load: if (!cmd_empty) state <= exec_event;
                exec_event: if (action) state <= exec_load;
                default: state <= exec_load;
            endcase
        end
    end

    // command and readback are sampled together on the load edge
    always_ff @(posedge clock) begin
        if (state == exec_load && !cmd_empty) begin
            cmd_reg <= cmd_entry;
            rb_data <= readback[cmd_entry.hdr[3:0]];
        end
    end

    // --------------------
    // settings bus
    // --------------------

    // one cycle pulse after a poke fires
    always_ff @(posedge clock) begin
        if (reset)
            strobe <= 1'b0;
        else
            strobe <= action && cmd_reg.hdr[8];
    end

    // cmd_reg still holds the fired command while strobe is high
    assign addr = cmd_reg.hdr[7:0];
    assign data = cmd_reg.data;

    // the queue head stays the loaded command until the action pops it
    head_held: assert property (@(posedge clock) disable iff (reset)
        (state == exec_event) |-> !cmd_empty && (cmd_entry.hdr == cmd_reg.hdr)
            && (cmd_entry.data == cmd_reg.data));

endmodule

//--- hdl/cmd_decode.sv
// --------------------
// cmd_decode
// parses one command packet per frame into a command entry
// optional stream header fields are skipped, tsf becomes the trigger time
// --------------------
module cmd_decode (
    input  logic                   clock,
    input  logic                   reset,
    input  ctrl_pkg::stream_word_t in_word,
    input  logic                   in_valid,
    input  logic                   cmd_full,
    output logic                   in_ready,
    output logic                   cmd_write,
    output ctrl_pkg::command_t     cmd_entry
);
    import ctrl_pkg::*;

    decode_state_t state;
    logic          taking;

    // presence flags of the current stream header
    logic hdr_sid;
    logic hdr_cid;
    logic hdr_tsi;
    logic hdr_tsf;
    logic has_cid_reg;
    logic has_tsi_reg;

    // entry under construction, has_time doubles as the tsf flag
    command_t entry_reg;

    // first optional field still to come, or the command header
    function automatic decode_state_t next_field(input logic sid, input logic cid,
                                                 input logic tsi, input logic tsf);
        if (sid)
            return vita_sid;
        else if (cid)
            return vita_cid0;
        else if (tsi)
            return vita_tsi;
        else if (tsf)
            return vita_tsf0;
        return cmd_hdr;
    endfunction

    assign taking = in_valid && in_ready;
    assign hdr_sid = in_word.data[28];
    assign hdr_cid = in_word.data[27];
    assign hdr_tsi = (in_word.data[23:22] != 2'b00);
    assign hdr_tsf = (in_word.data[21:20] != 2'b00);

    // input stalls only while the finished entry waits for room
    assign in_ready = (state != store_cmd);
    assign cmd_write = (state == store_cmd) && !cmd_full;
    assign cmd_entry = entry_reg;

    // --------------------
    // packet walk
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= line0;
        end else begin
            case (state)
                // protocol header, contents unused
                line0: if (taking) state <= vita_hdr;
                vita_hdr: if (taking) state <= next_field(hdr_sid, hdr_cid, hdr_tsi, hdr_tsf);
                vita_sid: if (taking)
                    state <= next_field(1'b0, has_cid_reg, has_tsi_reg, entry_reg.has_time);
                vita_cid0: if (taking) state <= vita_cid1;
                vita_cid1: if (taking)
                    state <= next_field(1'b0, 1'b0, has_tsi_reg, entry_reg.has_time);
                vita_tsi: if (taking)
                    state <= next_field(1'b0, 1'b0, 1'b0, entry_reg.has_time);
                vita_tsf0: if (taking) state <= vita_tsf1;
                vita_tsf1: if (taking) state <= cmd_hdr;
                cmd_hdr: if (taking) state <= cmd_data;
                // a bare packet ends on the data word
                cmd_data: if (taking) state <= in_word.eof ? store_cmd : wait_eof;
                // trailing words are dropped
                wait_eof: if (taking && in_word.eof) state <= store_cmd;
                store_cmd: if (!cmd_full) state <= line0;
                default: state <= line0;
            endcase
        end
    end

    // --------------------
    // field capture
    // --------------------
    always_ff @(posedge clock) begin
        if (taking) begin
            case (state)
                vita_hdr: begin
                    has_cid_reg <= hdr_cid;
                    has_tsi_reg <= hdr_tsi;
                    entry_reg.has_time <= hdr_tsf;
                end
                vita_tsf0: entry_reg.ticks[63:32] <= in_word.data;
                vita_tsf1: entry_reg.ticks[31:0] <= in_word.data;
                cmd_hdr: entry_reg.hdr <= in_word.data;
                cmd_data: entry_reg.data <= in_word.data;
                default: ;
            endcase
        end
    end

    // every packet opens with its sof word
    packet_start: assert property (@(posedge clock) disable iff (reset)
        taking && (state == line0) |-> in_word.sof);

    // eof before the command data word would cut the packet short
    eof_placement: assert property (@(posedge clock) disable iff (reset)
        taking && in_word.eof |-> (state == cmd_data) || (state == wait_eof));

endmodule

//--- hdl/entry_fifo.sv
// --------------------
// entry_fifo
// synchronous circular buffer for packed entries
// the head entry is visible on read_data while not empty
// --------------------
`include "ctrl_config.svh"

module entry_fifo #(
    parameter int width = 32
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             write,
    input  logic [width-1:0] write_data,
    input  logic             read,
    output logic [width-1:0] read_data,
    output logic             full,
    output logic             empty
);
    localparam int depth_log2 = `CTRL_FIFO_DEPTH_LOG2;
    localparam int depth = 1 << depth_log2;

    logic [width-1:0]      mem [depth];
    logic [depth_log2-1:0] write_ptr;
    logic [depth_log2-1:0] read_ptr;
    // one extra bit so a full buffer is distinct from an empty one
    logic [depth_log2:0]   count;

    assign full = (count == (depth_log2 + 1)'(depth));
    assign empty = (count == '0);
    assign read_data = mem[read_ptr];

    // storage, no reset on the payload
    always_ff @(posedge clock) begin
        if (write)
            mem[write_ptr] <= write_data;
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clock) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr <= '0;
            count <= '0;
        end else begin
            if (write)
                write_ptr <= write_ptr + 1'b1;
            if (read)
                read_ptr <= read_ptr + 1'b1;
            case ({write, read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producers and consumers must honour the flags
    no_overflow: assert property (@(posedge clock) disable iff (reset) write |-> !full);
    no_underflow: assert property (@(posedge clock) disable iff (reset) read |-> !empty);

endmodule

//--- hdl/ctrl_pkg.sv
// --------------------
// ctrl_pkg
// stream, command and result types plus the state encodings
// of the settings readback controller
// --------------------
package ctrl_pkg;

    // one stream word with its framing flags
    typedef struct packed {
        logic        eof;
        logic        sof;
        logic [31:0] data;
    } stream_word_t;

    // one decoded command, as queued between decode and execute
    // hdr[7:0] settings address
    // hdr[8] poke enable
    // hdr[3:0] readback select
    // hdr[19:16] sequence number echoed in the response
    typedef struct packed {
        logic [63:0] ticks;
        logic [31:0] hdr;
        logic [31:0] data;
        logic        has_time;
    } command_t;

    // outcome of one command, ticks is the execution time
    typedef struct packed {
        logic [63:0] ticks;
        logic [31:0] hdr;
        logic [31:0] data;
    } result_t;

    // sixteen readback words, index 0 in the low bits
    typedef logic [15:0][31:0] readback_t;

    // input packet walk
    typedef enum logic [3:0] {
        line0, vita_hdr, vita_sid, vita_cid0, vita_cid1, vita_tsi,
        vita_tsf0, vita_tsf1, cmd_hdr, cmd_data, wait_eof, store_cmd
    } decode_state_t;

    // execute stage, event is reserved so the names carry a prefix
    typedef enum logic {
        exec_load,
        exec_event
    } exec_state_t;

    // response word index
    typedef enum logic [2:0] {
        prot_hdr, vrt_hdr, vrt_sid, tsf_hi, tsf_lo, rb_hdr, rb_data
    } frame_state_t;

endpackage

//--- hdl/ctrl_config.svh
// --------------------
// settings readback controller configuration
// sizes and constant fields shared by the FIFOs and the response framer
// --------------------
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// --------------------
// queue sizing
// --------------------

// log2 of the entry count in each FIFO, 2 gives 4 entries
`define CTRL_FIFO_DEPTH_LOG2 2

// --------------------
// response packet fields
// --------------------

// stream id written into every response
`define CTRL_SID 32'h0000_00a5
// destination field of the protocol header
`define CTRL_PROT_DEST 2'd2
// bytes in the stream part of a response, six words
`define CTRL_RESP_BYTES 24

`endif
